// ==== hw/ppu_pkg.sv ====
`default_nettype none

package ppu_pkg;

    // ------------------------------------------------------------
    // Widths
    // ------------------------------------------------------------
    typedef logic [9:0]  vga_coord_t;
    typedef logic [8:0]  ppu_coord_t;
    typedef logic [7:0]  oam_addr_t;
    typedef logic [12:0] chr_addr_t;
    typedef logic [7:0]  byte_t;
    // Palette bits on top, pattern bits below
    typedef logic [3:0]  pal_index_t;
    typedef logic [5:0]  color_t;
    // R, G, B nibbles
    typedef logic [11:0] rgb_t;
    typedef logic [2:0]  slot_id_t;

    // Sprite evaluator FSM
    typedef enum logic [2:0] {
        idle,
        check_y,
        read_attr,
        read_tile,
        read_lo,
        read_hi,
        done
    } eval_state_t;

    // ------------------------------------------------------------
    // Raster, each line starts with the back porch
    // ------------------------------------------------------------
    localparam vga_coord_t H_VISIBLE = 10'd640;
    localparam vga_coord_t H_FRONT   = 10'd16;
    localparam vga_coord_t H_SYNC    = 10'd96;
    localparam vga_coord_t H_BACK    = 10'd48;
    localparam vga_coord_t H_TOTAL   = 10'd800;
    localparam vga_coord_t V_VISIBLE = 10'd480;
    localparam vga_coord_t V_FRONT   = 10'd10;
    localparam vga_coord_t V_SYNC    = 10'd2;
    localparam vga_coord_t V_BACK    = 10'd33;
    localparam vga_coord_t V_TOTAL   = 10'd525;

    // Paper area in processor pixels
    localparam ppu_coord_t PAPER_X0 = 9'd32;
    localparam ppu_coord_t PAPER_W  = 9'd256;
    localparam ppu_coord_t PAPER_Y0 = 9'd16;
    localparam ppu_coord_t PAPER_Y1 = 9'd256;

    localparam int OAM_ENTRIES = 64;
    localparam int SLOT_COUNT  = 8;
    localparam int SPRITE_H    = 8;

    // Pattern table half used by sprites
    localparam logic CHR_SPRITE_TABLE = 1'b1;

    // Fixed sprite palette, four colors per palette
    localparam color_t SPRITE_PAL [16] = '{
        6'h0F, 6'h16, 6'h27, 6'h12,
        6'h0F, 6'h30, 6'h2B, 6'h16,
        6'h0F, 6'h39, 6'h28, 6'h27,
        6'h0F, 6'h30, 6'h30, 6'h30
    };

    // Master color table
    localparam rgb_t MASTER_RGB [64] = '{
        12'h777, 12'h218, 12'h00A, 12'h409, 12'h807, 12'hA01, 12'hA00, 12'h700,
        12'h420, 12'h040, 12'h050, 12'h031, 12'h135, 12'h000, 12'h000, 12'h000,
        12'hBBB, 12'h07E, 12'h23E, 12'h80F, 12'hB0B, 12'hE05, 12'hD20, 12'hC40,
        12'h870, 12'h090, 12'h0A0, 12'h093, 12'h088, 12'h000, 12'h000, 12'h000,
        12'hFFF, 12'h3BF, 12'h59F, 12'hA8F, 12'hF7F, 12'hF7B, 12'hF76, 12'hF93,
        12'hFB3, 12'h8D1, 12'h4D4, 12'h5F9, 12'h0ED, 12'h000, 12'h000, 12'h000,
        12'hFFF, 12'hAEF, 12'hCDF, 12'hDCF, 12'hFCF, 12'hFCD, 12'hFBB, 12'hFDA,
        12'hFEA, 12'hEFA, 12'hAFB, 12'hBFC, 12'h9FF, 12'h000, 12'h000, 12'h000
    };

    localparam rgb_t BLACK_RGB = 12'h000;

endpackage

`default_nettype wire

// ==== hw/video_timing.sv ====
`timescale 1ns/1ps
`default_nettype none

module video_timing (
    input  wire                 clock25,
    input  wire                 reset_n,
    output logic                hs_o,
    output logic                vs_o,
    output ppu_pkg::ppu_coord_t px_o,
    output ppu_pkg::ppu_coord_t py_o,
    output logic                line_start_o,
    output logic                pixel_strobe_o
);

    ppu_pkg::vga_coord_t x;
    ppu_pkg::vga_coord_t y;
    ppu_pkg::vga_coord_t x_rel;
    ppu_pkg::vga_coord_t h_sync_start;
    ppu_pkg::vga_coord_t v_sync_start;
    logic                x_last;
    logic                y_last;
    logic                paper_x;
    logic                paper_y;

    // ------------------------------------------------------------
    // Raster counters 800 x 525
    // ------------------------------------------------------------
    assign x_last = (x == ppu_pkg::H_TOTAL - 10'd1);
    assign y_last = (y == ppu_pkg::V_TOTAL - 10'd1);

    always_ff @(posedge clock25) begin
        if (!reset_n) begin
            x <= '0;
            y <= '0;
        end else begin
            x <= x_last ? '0 : x + 10'd1;
            if (x_last) begin
                y <= y_last ? '0 : y + 10'd1;
            end
        end
    end

    // Sync pulses after back porch, visible and front porch
    assign h_sync_start = ppu_pkg::H_BACK + ppu_pkg::H_VISIBLE + ppu_pkg::H_FRONT;
    assign v_sync_start = ppu_pkg::V_BACK + ppu_pkg::V_VISIBLE + ppu_pkg::V_FRONT;

    // Both negative
    assign hs_o = !(x >= h_sync_start && x < h_sync_start + ppu_pkg::H_SYNC);
    assign vs_o = !(y >= v_sync_start && y < v_sync_start + ppu_pkg::V_SYNC);

    // ------------------------------------------------------------
    // Processor positions, 2x2 VGA pixels each
    // ------------------------------------------------------------
    assign x_rel = x - ppu_pkg::H_BACK;
    // Wraps high left of the back porch, never inside paper
    assign px_o  = x_rel[9:1];
    assign py_o  = y[9:1];

    assign paper_x = (px_o >= ppu_pkg::PAPER_X0)
                  && (px_o < ppu_pkg::PAPER_X0 + ppu_pkg::PAPER_W);
    assign paper_y = (py_o >= ppu_pkg::PAPER_Y0) && (py_o < ppu_pkg::PAPER_Y1);

    // Evaluator kick at the start of the even half of a paper line
    assign line_start_o = (x == '0) && !y[0] && paper_y;

    // Second VGA clock of a processor pixel, odd half only
    assign pixel_strobe_o = x[0] && y[0] && paper_x && paper_y;

    // Paper window on the raw VGA counter, x 112..623
    a_strobe_in_paper: assert property (@(posedge clock25) disable iff (!reset_n)
        pixel_strobe_o |-> (x >= ppu_pkg::H_BACK + 10'(2 * ppu_pkg::PAPER_X0))
                        && (x < ppu_pkg::H_BACK
                               + 10'(2 * (ppu_pkg::PAPER_X0 + ppu_pkg::PAPER_W))));

endmodule

`default_nettype wire

// ==== hw/sprite_evaluator.sv ====
`timescale 1ns/1ps
`default_nettype none

module sprite_evaluator (
    input  wire                 clock25,
    input  wire                 reset_n,
    input  wire                 line_start_i,
    input  wire ppu_pkg::ppu_coord_t py_i,
    input  wire ppu_pkg::byte_t oam_data_i,
    input  wire ppu_pkg::byte_t chr_data_i,
    output ppu_pkg::oam_addr_t  oam_addr_o,
    output ppu_pkg::chr_addr_t  chr_addr_o,
    output logic                clear_o,
    output logic [7:0]          load_strobe_o,
    output ppu_pkg::byte_t      load_x_o,
    output ppu_pkg::byte_t      load_attr_o,
    output ppu_pkg::byte_t      load_lo_o,
    output ppu_pkg::byte_t      load_hi_o
);

    ppu_pkg::eval_state_t state;
    ppu_pkg::slot_id_t    count;
    ppu_pkg::byte_t       ry;
    ppu_pkg::byte_t       dy;
    ppu_pkg::byte_t       chr_rev;
    ppu_pkg::byte_t       chr_line;
    logic [2:0]           row;
    logic                 flip_h;
    logic                 y_hit;
    logic                 last_entry;
    logic                 last_q;
    logic [3:0]           loads_seen;

    // ------------------------------------------------------------
    // Row test against the Y byte on the OAM bus
    // ------------------------------------------------------------
    assign dy    = ry - oam_data_i;
    assign y_hit = (ry >= oam_data_i) && (dy < 8'(ppu_pkg::SPRITE_H));

    // Entry 63 starts at byte 252
    assign last_entry = (oam_addr_o == ppu_pkg::oam_addr_t'(4 * (ppu_pkg::OAM_ENTRIES - 1)));

    // Horizontal flip mirrors both planes
    assign chr_rev  = {<<{chr_data_i}};
    assign chr_line = flip_h ? chr_rev : chr_data_i;

    // ------------------------------------------------------------
    // Evaluator FSM
    // ------------------------------------------------------------
    always_ff @(posedge clock25) begin
        if (!reset_n) begin
            state         <= ppu_pkg::idle;
            count         <= '0;
            oam_addr_o    <= '0;
            chr_addr_o    <= '0;
            clear_o       <= 1'b0;
            load_strobe_o <= '0;
        end else begin
            // Slots emptied one clock after the kick
            clear_o       <= line_start_i;
            load_strobe_o <= '0;

            if (line_start_i) begin
                state      <= ppu_pkg::check_y;
                count      <= '0;
                oam_addr_o <= '0;
                ry         <= ppu_pkg::byte_t'(py_i - ppu_pkg::PAPER_Y0);
            end else begin
                case (state)
                    // Y byte of the entry
                    ppu_pkg::check_y: begin
                        if (y_hit) begin
                            row        <= dy[2:0];
                            last_q     <= last_entry;
                            oam_addr_o <= oam_addr_o + 8'd2;
                            state      <= ppu_pkg::read_attr;
                        end else if (last_entry) begin
                            state <= ppu_pkg::done;
                        end else begin
                            oam_addr_o <= oam_addr_o + 8'd4;
                        end
                    end

                    // Attribute byte, bit 7 flips the row
                    ppu_pkg::read_attr: begin
                        load_attr_o <= oam_data_i;
                        flip_h      <= oam_data_i[6];
                        if (oam_data_i[7]) begin
                            row <= ~row;
                        end
                        oam_addr_o <= oam_addr_o - 8'd1;
                        state      <= ppu_pkg::read_tile;
                    end

                    // Tile byte, low plane address
                    ppu_pkg::read_tile: begin
                        chr_addr_o <= {ppu_pkg::CHR_SPRITE_TABLE, oam_data_i, 1'b0, row};
                        oam_addr_o <= oam_addr_o + 8'd2;
                        state      <= ppu_pkg::read_lo;
                    end

                    // X byte and low plane together
                    ppu_pkg::read_lo: begin
                        load_x_o      <= oam_data_i;
                        load_lo_o     <= chr_line;
                        chr_addr_o[3] <= 1'b1;
                        // Next entry base
                        oam_addr_o    <= oam_addr_o + 8'd1;
                        state         <= ppu_pkg::read_hi;
                    end

                    // High plane, then hand over to the slot
                    ppu_pkg::read_hi: begin
                        load_hi_o            <= chr_line;
                        load_strobe_o[count] <= 1'b1;
                        count                <= count + 3'd1;
                        if (count == 3'd7 || last_q) begin
                            state <= ppu_pkg::done;
                        end else begin
                            state <= ppu_pkg::check_y;
                        end
                    end

                    // Idle after reset, done until next kick
                    default: begin
                        state <= state;
                    end
                endcase
            end
        end
    end

    // Loads since the last kick
    always_ff @(posedge clock25) begin
        if (!reset_n || line_start_i) begin
            loads_seen <= '0;
        end else if (|load_strobe_o) begin
            loads_seen <= loads_seen + 4'd1;
        end
    end

    a_max_eight_loads: assert property (@(posedge clock25) disable iff (!reset_n)
        |load_strobe_o |-> loads_seen < 4'd8);

endmodule

`default_nettype wire

// ==== hw/sprite_slot.sv ====
`timescale 1ns/1ps
`default_nettype none

module sprite_slot (
    input  wire                      clock25,
    input  wire                      reset_n,
    input  wire                      clear_i,
    input  wire                      load_i,
    input  wire ppu_pkg::byte_t      x_i,
    input  wire ppu_pkg::byte_t      attr_i,
    input  wire ppu_pkg::byte_t      lo_i,
    input  wire ppu_pkg::byte_t      hi_i,
    input  wire ppu_pkg::ppu_coord_t px_i,
    output logic                     opaque_o,
    output ppu_pkg::pal_index_t      index_o
);

    logic           valid;
    logic [1:0]     pal_q;
    ppu_pkg::byte_t x_q;
    ppu_pkg::byte_t lo_q;
    ppu_pkg::byte_t hi_q;
    ppu_pkg::byte_t rx;
    ppu_pkg::byte_t dx;
    logic [2:0]     bit_sel;
    logic           in_range;
    logic           lo_bit;
    logic           hi_bit;

    // Valid from load until the next line clear
    always_ff @(posedge clock25) begin
        if (!reset_n) begin
            valid <= 1'b0;
        end else if (load_i) begin
            valid <= 1'b1;
        end else if (clear_i) begin
            valid <= 1'b0;
        end
    end

    // Sprite line data
    always_ff @(posedge clock25) begin
        if (load_i) begin
            x_q   <= x_i;
            pal_q <= attr_i[1:0];
            lo_q  <= lo_i;
            hi_q  <= hi_i;
        end
    end

    // Paper-relative x and offset into the sprite
    assign rx = ppu_pkg::byte_t'(px_i - ppu_pkg::PAPER_X0);
    assign dx = rx - x_q;

    // No wrap past the right edge
    assign in_range = valid && (rx >= x_q) && (dx < 8'd8);

    // Leftmost pixel in bit 7
    assign bit_sel = 3'd7 - dx[2:0];
    assign lo_bit  = lo_q[bit_sel];
    assign hi_bit  = hi_q[bit_sel];

    assign opaque_o = in_range && (lo_bit || hi_bit);
    assign index_o  = {pal_q, hi_bit, lo_bit};

endmodule

`default_nettype wire

// ==== hw/pixel_mixer.sv ====
`timescale 1ns/1ps
`default_nettype none

module pixel_mixer (
    input  wire                              clock25,
    input  wire                              reset_n,
    input  wire [ppu_pkg::SLOT_COUNT-1:0]    opaque_i,
    input  wire ppu_pkg::pal_index_t         index_i [ppu_pkg::SLOT_COUNT],
    input  wire                              pixel_strobe_i,
    output ppu_pkg::rgb_t                    rgb_o
);

    ppu_pkg::pal_index_t winner;
    ppu_pkg::color_t     color;

    // ------------------------------------------------------------
    // Priority, slot 0 highest
    // ------------------------------------------------------------
    always_comb begin
        // Entry 0 is the backdrop color
        winner = '0;
        // Walk down so the lowest opaque slot is taken last
        for (int i = ppu_pkg::SLOT_COUNT - 1; i >= 0; i--) begin
            if (opaque_i[i]) begin
                winner = index_i[i];
            end
        end
    end

    assign color = ppu_pkg::SPRITE_PAL[winner];

    // Output register, black between strobes
    always_ff @(posedge clock25) begin
        if (!reset_n) begin
            rgb_o <= ppu_pkg::BLACK_RGB;
        end else if (pixel_strobe_i) begin
            rgb_o <= ppu_pkg::MASTER_RGB[color];
        end else begin
            rgb_o <= ppu_pkg::BLACK_RGB;
        end
    end

    // Single-cycle strobe leaves a black cycle between pixels
    a_strobe_single: assert property (@(posedge clock25) disable iff (!reset_n)
        pixel_strobe_i |=> !pixel_strobe_i);

endmodule

`default_nettype wire

// ==== hw/sprite_ppu.sv ====
`timescale 1ns/1ps
`default_nettype none

module sprite_ppu (
    input  wire                 clock25,
    input  wire                 reset_n,
    input  wire ppu_pkg::byte_t oam_data_i,
    input  wire ppu_pkg::byte_t chr_data_i,
    output logic                hs_o,
    output logic                vs_o,
    output ppu_pkg::rgb_t       rgb_o,
    output ppu_pkg::ppu_coord_t px_o,
    output ppu_pkg::ppu_coord_t py_o,
    output logic                pixel_strobe_o,
    output ppu_pkg::oam_addr_t  oam_addr_o,
    output ppu_pkg::chr_addr_t  chr_addr_o
);

    ppu_pkg::ppu_coord_t            px;
    ppu_pkg::ppu_coord_t            py;
    logic                           line_start;
    logic                           pixel_strobe;
    logic                           clear;
    logic [7:0]                     load_strobe;
    ppu_pkg::byte_t                 load_x;
    ppu_pkg::byte_t                 load_attr;
    ppu_pkg::byte_t                 load_lo;
    ppu_pkg::byte_t                 load_hi;
    logic [ppu_pkg::SLOT_COUNT-1:0] slot_opaque;
    ppu_pkg::pal_index_t            slot_index [ppu_pkg::SLOT_COUNT];

    video_timing u_timing (
        .clock25        (clock25),
        .reset_n        (reset_n),
        .hs_o           (hs_o),
        .vs_o           (vs_o),
        .px_o           (px),
        .py_o           (py),
        .line_start_o   (line_start),
        .pixel_strobe_o (pixel_strobe)
    );

    sprite_evaluator u_evaluator (
        .clock25       (clock25),
        .reset_n       (reset_n),
        .line_start_i  (line_start),
        .py_i          (py),
        .oam_data_i    (oam_data_i),
        .chr_data_i    (chr_data_i),
        .oam_addr_o    (oam_addr_o),
        .chr_addr_o    (chr_addr_o),
        .clear_o       (clear),
        .load_strobe_o (load_strobe),
        .load_x_o      (load_x),
        .load_attr_o   (load_attr),
        .load_lo_o     (load_lo),
        .load_hi_o     (load_hi)
    );

    // Eight slots share the load bus, each on its own strobe
    for (genvar i = 0; i < ppu_pkg::SLOT_COUNT; i++) begin : g_slot
        sprite_slot u_slot (
            .clock25  (clock25),
            .reset_n  (reset_n),
            .clear_i  (clear),
            .load_i   (load_strobe[i]),
            .x_i      (load_x),
            .attr_i   (load_attr),
            .lo_i     (load_lo),
            .hi_i     (load_hi),
            .px_i     (px),
            .opaque_o (slot_opaque[i]),
            .index_o  (slot_index[i])
        );
    end

    pixel_mixer u_mixer (
        .clock25        (clock25),
        .reset_n        (reset_n),
        .opaque_i       (slot_opaque),
        .index_i        (slot_index),
        .pixel_strobe_i (pixel_strobe),
        .rgb_o          (rgb_o)
    );

    // Position and strobe delayed to match the registered color
    always_ff @(posedge clock25) begin
        if (!reset_n) begin
            px_o           <= '0;
            py_o           <= '0;
            pixel_strobe_o <= 1'b0;
        end else begin
            px_o           <= px;
            py_o           <= py;
            pixel_strobe_o <= pixel_strobe;
        end
    end

endmodule

`default_nettype wire

// ==== test/tb_clock_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic clock25_o,
    output logic reset_n_o
);

    // 100 ns period
    initial begin
        clock25_o = 1'b0;
    end

    always begin
        #50 clock25_o = ~clock25_o;
    end

    // Reset held for 16 rising edges, released just after the edge
    initial begin
        reset_n_o = 1'b0;
        repeat (16) @(posedge clock25_o);
        #1 reset_n_o = 1'b1;
    end

endmodule

`default_nettype wire

// ==== test/tb_sprite_ppu.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_sprite_ppu;

    logic                clock25;
    logic                reset_n;
    ppu_pkg::byte_t      oam_data;
    ppu_pkg::byte_t      chr_data;
    logic                hs;
    logic                vs;
    ppu_pkg::rgb_t       rgb;
    ppu_pkg::ppu_coord_t px;
    ppu_pkg::ppu_coord_t py;
    logic                pixel_strobe;
    ppu_pkg::oam_addr_t  oam_addr;
    ppu_pkg::chr_addr_t  chr_addr;

    ppu_pkg::byte_t oam_mem [256];
    integer         seed;
    integer         error_count;
    integer         hs_low;
    integer         vs_low;
    integer         vs_pulses;
    integer         strobe_run;
    integer         strobe_total;
    integer         line_idx;
    logic           hs_prev;
    ppu_pkg::ppu_coord_t exp_px;
    ppu_pkg::ppu_coord_t exp_py;

    tb_clock_gen u_clock (
        .clock25_o (clock25),
        .reset_n_o (reset_n)
    );

    sprite_ppu DUT (
        .clock25        (clock25),
        .reset_n        (reset_n),
        .oam_data_i     (oam_data),
        .chr_data_i     (chr_data),
        .hs_o           (hs),
        .vs_o           (vs),
        .rgb_o          (rgb),
        .px_o           (px),
        .py_o           (py),
        .pixel_strobe_o (pixel_strobe),
        .oam_addr_o     (oam_addr),
        .chr_addr_o     (chr_addr)
    );

    // ------------------------------------------------------------
    // Memory models, asynchronous read
    // ------------------------------------------------------------
    // Pattern byte hashed from the full address
    function automatic ppu_pkg::byte_t chr_byte(ppu_pkg::chr_addr_t a);
        logic [15:0] h;
        h = {3'b000, a} * 16'h2f5b;
        return h[12:5] ^ {a[12:9], a[3:0]};
    endfunction

    assign oam_data = oam_mem[oam_addr];
    assign chr_data = chr_byte(chr_addr);

    // Random OAM, first 48 entries crowded into 32 rows from base
    task automatic fill_oam(ppu_pkg::byte_t base);
        integer r;
        for (int i = 0; i < 256; i++) begin
            r = $random(seed);
            oam_mem[i] = r[7:0];
        end
        for (int e = 0; e < 48; e++) begin
            oam_mem[4 * e] = base + (oam_mem[4 * e] & 8'h1f);
        end
    endtask

    // ------------------------------------------------------------
    // Reference pixel
    // ------------------------------------------------------------
    function automatic ppu_pkg::rgb_t expected_rgb(ppu_pkg::ppu_coord_t x,
                                                   ppu_pkg::ppu_coord_t y);
        ppu_pkg::byte_t      ry;
        ppu_pkg::byte_t      rx;
        ppu_pkg::byte_t      dy;
        ppu_pkg::byte_t      dx;
        ppu_pkg::byte_t      attr;
        ppu_pkg::byte_t      lo;
        ppu_pkg::byte_t      hi;
        ppu_pkg::chr_addr_t  addr;
        ppu_pkg::pal_index_t idx;
        logic [2:0]          row;
        logic [1:0]          pix;
        logic                hit;
        integer              found;
        idx   = '0;
        hit   = 1'b0;
        found = 0;
        ry    = ppu_pkg::byte_t'(y - ppu_pkg::PAPER_Y0);
        rx    = ppu_pkg::byte_t'(x - ppu_pkg::PAPER_X0);
        // OAM order, first eight row matches only
        for (int e = 0; e < 64; e++) begin
            dy = ry - oam_mem[4 * e];
            if (found < 8 && ry >= oam_mem[4 * e] && dy < 8'd8) begin
                found = found + 1;
                attr  = oam_mem[4 * e + 2];
                row   = attr[7] ? 3'd7 - dy[2:0] : dy[2:0];
                addr  = {1'b1, oam_mem[4 * e + 1], 1'b0, row};
                lo    = chr_byte(addr);
                hi    = chr_byte(addr | 13'h008);
                if (attr[6]) begin
                    lo = {<<{lo}};
                    hi = {<<{hi}};
                end
                dx = rx - oam_mem[4 * e + 3];
                if (!hit && rx >= oam_mem[4 * e + 3] && dx < 8'd8) begin
                    pix = {hi[3'd7 - dx[2:0]], lo[3'd7 - dx[2:0]]};
                    // Earlier opaque entry takes the pixel
                    if (pix != 2'b00) begin
                        hit = 1'b1;
                        idx = {attr[1:0], pix};
                    end
                end
            end
        end
        return ppu_pkg::MASTER_RGB[ppu_pkg::SPRITE_PAL[idx]];
    endfunction

    // ------------------------------------------------------------
    // Failure and compare tasks
    // ------------------------------------------------------------
    task automatic stop_run();
        $display("TEST FAILED");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic check_rgb(ppu_pkg::rgb_t got, ppu_pkg::rgb_t exp, string what);
        if (got !== exp) begin
            error_count = error_count + 1;
            $display("[FAIL] %0d ns: %s rgb %03h, expected %03h", $time, what, got, exp);
            stop_run();
        end
    endtask

    task automatic check_count(integer got, integer exp, string what);
        if (got !== exp) begin
            error_count = error_count + 1;
            $display("[FAIL] %0d ns: %s is %0d, expected %0d", $time, what, got, exp);
            stop_run();
        end
    endtask

    task automatic wait_vs(logic level, integer limit);
        integer n;
        n = 0;
        while (vs !== level) begin
            @(negedge clock25);
            n = n + 1;
            if (n > limit) begin
                $display("Timeout: vs_o never went to %0d", level);
                stop_run();
            end
        end
    endtask

    // Outputs sampled mid-cycle, away from the clock edge
    always @(negedge clock25) begin
        if (reset_n) begin
            if (pixel_strobe) begin
                // Position from the strobe count within the line and the line count
                exp_px = ppu_pkg::ppu_coord_t'(32 + strobe_run);
                exp_py = ppu_pkg::ppu_coord_t'(line_idx / 2);
                check_count(32'(px), 32'(exp_px), "px_o");
                check_count(32'(py), 32'(exp_py), "py_o");
                check_rgb(rgb, expected_rgb(exp_px, exp_py),
                          $sformatf("pixel (%0d,%0d)", exp_px, exp_py));
                strobe_run   = strobe_run + 1;
                strobe_total = strobe_total + 1;
            end else begin
                check_rgb(rgb, ppu_pkg::BLACK_RGB, "blanked output");
            end
            // Sync pulse widths
            if (!hs) begin
                hs_low = hs_low + 1;
            end else if (hs_low != 0) begin
                check_count(hs_low, 96, "hs_o low cycles");
                hs_low = 0;
            end
            if (!vs) begin
                vs_low = vs_low + 1;
            end else if (vs_low != 0) begin
                check_count(vs_low, 2 * 800, "vs_o low cycles");
                vs_low    = 0;
                vs_pulses = vs_pulses + 1;
                line_idx  = 0;
            end
            // Strobes per VGA line, closed at the hsync edge
            if (hs_prev && !hs) begin
                if (line_idx % 2 == 1 && line_idx / 2 >= 16 && line_idx / 2 < 256) begin
                    check_count(strobe_run, 256, $sformatf("strobes on line %0d", line_idx));
                end else begin
                    check_count(strobe_run, 0, $sformatf("strobes on line %0d", line_idx));
                end
                strobe_run = 0;
                line_idx   = line_idx + 1;
            end
            hs_prev = hs;
        end
    end

    // ------------------------------------------------------------
    // Main sequence, two frames
    // ------------------------------------------------------------
    initial begin
        integer n;
        seed         = 32'h4e1b92a6;
        error_count  = 0;
        hs_low       = 0;
        vs_low       = 0;
        vs_pulses    = 0;
        strobe_run   = 0;
        strobe_total = 0;
        line_idx     = 0;
        hs_prev      = 1'b1;
        fill_oam(8'd40);
        n = 0;
        while (reset_n !== 1'b1) begin
            @(negedge clock25);
            n = n + 1;
            if (n > 100) begin
                $display("Timeout: reset_n never released");
                stop_run();
            end
        end
        // New OAM for frame two during vertical sync
        wait_vs(1'b0, 500000);
        @(posedge clock25);
        #1;
        fill_oam(8'd120);
        wait_vs(1'b1, 5000);
        wait_vs(1'b0, 500000);
        // Second vsync pulse closed by the monitor before the totals
        wait_vs(1'b1, 5000);
        @(negedge clock25);
        check_count(strobe_total, 2 * 240 * 256, "pixel strobes in two frames");
        check_count(vs_pulses, 2, "vsync pulses measured");
        if (error_count == 0) begin
            $display("TEST OK");
            $finish;
        end else begin
            stop_run();
        end
    end

endmodule

`default_nettype wire

// ==== sprite_ppu.f ====
hw/ppu_pkg.sv
hw/video_timing.sv
hw/sprite_evaluator.sv
hw/sprite_slot.sv
hw/pixel_mixer.sv
hw/sprite_ppu.sv
test/tb_clock_gen.sv
test/tb_sprite_ppu.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the sprite PPU testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module tb_sprite_ppu -f sprite_ppu.f -o sim_tb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/sim_tb 2>&1)
status=$?
printf '%s\n' "$output"

if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "TEST OK"; then
    exit 0
fi

echo "Pass line not found in simulation output"
exit 1
